/* Bender.yml */
package:
  name: zynq_pl_glue

sources:
  - zynq_pkg.sv
  - pl_ctrl_if.sv
  - csr_bank.sv
  - addr_remap.sv
  - mem_profiler.sv
  - zynq_top.sv
  - target: test
    files:
      - tb_zynq_top.sv

/* addr_remap.sv */
`timescale 1ns/1ns
`default_nettype none

module addr_remap (
   input  wire logic                                clk_i,
   input  wire logic                                reset_i,
   input  wire logic                                host_v_i,
   input  wire logic [zynq_pkg::host_win_width-1:0] host_addr_i,
   output logic                                     core_v_o,
   output zynq_pkg::core_addr_t                     core_addr_o,
   input  wire logic                                dram_v_i,
   input  wire logic                                dram_we_i,
   input  wire zynq_pkg::core_addr_t                dram_addr_i,
   output logic                                     mem_v_o,
   output logic                                     mem_we_o,
   output zynq_pkg::core_addr_t                     mem_addr_o,
   pl_ctrl_if.remap                                 ctrl
);

   zynq_pkg::core_addr_t core_addr_n;
   zynq_pkg::core_addr_t mem_addr_n;
   logic                 core_v_r;
   zynq_pkg::core_addr_t core_addr_r;
   logic                 mem_v_r;
   logic                 mem_we_r;
   zynq_pkg::core_addr_t mem_addr_r;

   ////////////////////////////////////////
   // host window to core space
   ////////////////////////////////////////

   // window 0x0000_0000 lands on core DRAM at 0x8000_0000,
   // window 0x2000_0000 lands on core local space at 0x0
   assign core_addr_n = {~host_addr_i[29], 3'b000, host_addr_i[27:0]};

   ////////////////////////////////////////
   // core DRAM to host DRAM
   ////////////////////////////////////////

   // xor strips the core DRAM base, then offset into the host buffer
   assign mem_addr_n = (dram_addr_i ^ zynq_pkg::bp_dram_base) + ctrl.dram_base;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         core_v_r <= 1'b0;
         mem_v_r  <= 1'b0;
      end else begin
         core_v_r <= host_v_i;
         mem_v_r  <= dram_v_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (host_v_i) begin
         core_addr_r <= core_addr_n;
      end
      if (dram_v_i) begin
         mem_we_r   <= dram_we_i;
         mem_addr_r <= mem_addr_n;
      end
   end

   assign core_v_o    = core_v_r;
   assign core_addr_o = core_addr_r;
   assign mem_v_o     = mem_v_r;
   assign mem_we_o    = mem_we_r;
   assign mem_addr_o  = mem_addr_r;

   // profiler sees the core address, before the remap
   assign ctrl.dram_acc_v      = dram_v_i;
   assign ctrl.dram_acc_region = dram_addr_i[zynq_pkg::prof_msb:zynq_pkg::prof_lsb];

endmodule

`default_nettype wire

/* csr_bank.sv */
`timescale 1ns/1ns
`default_nettype none

module csr_bank #(
   parameter int csr_addr_width_p = 3
) (
   input  wire logic                                 clk_i,
   input  wire logic                                 reset_i,
   input  wire logic                                 csr_wr_v_i,
   input  wire logic                                 csr_rd_v_i,
   input  wire logic [csr_addr_width_p-1:0]          csr_addr_i,
   input  wire logic [zynq_pkg::host_data_width-1:0] csr_wdata_i,
   output logic                                      csr_rdata_v_o,
   output logic [zynq_pkg::host_data_width-1:0]      csr_rdata_o,
   output logic                                      core_reset_o,
   pl_ctrl_if.csr                                    ctrl
);

   localparam int dw_lp = zynq_pkg::host_data_width;

   logic [dw_lp-1:0] sys_resetn_r;
   logic [dw_lp-1:0] dram_base_r;
   logic [dw_lp-1:0] rdata_n;
   logic [dw_lp-1:0] rdata_r;
   logic             rdata_v_r;

   ////////////////////////////////////////
   // writable registers
   ////////////////////////////////////////

   // profiler words and unmapped addresses fall through untouched
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         sys_resetn_r <= '0;
         dram_base_r  <= '0;
      end else if (csr_wr_v_i) begin
         case (csr_addr_i)
            csr_addr_width_p'(zynq_pkg::CSR_SYS_RESETN): sys_resetn_r <= csr_wdata_i;
            csr_addr_width_p'(zynq_pkg::CSR_DRAM_BASE):  dram_base_r  <= csr_wdata_i;
            default: ;
         endcase
      end
   end

   // run bit is active low, core sits in reset until the host sets it
   assign core_reset_o    = ~sys_resetn_r[0];
   assign ctrl.core_reset = ~sys_resetn_r[0];
   assign ctrl.dram_base  = dram_base_r;

   ////////////////////////////////////////
   // read path
   ////////////////////////////////////////

   always_comb begin
      case (csr_addr_i)
         csr_addr_width_p'(zynq_pkg::CSR_SYS_RESETN): rdata_n = sys_resetn_r;
         csr_addr_width_p'(zynq_pkg::CSR_DRAM_BASE):  rdata_n = dram_base_r;
         csr_addr_width_p'(zynq_pkg::CSR_PROF_0):     rdata_n = ctrl.profile[0*dw_lp +: dw_lp];
         csr_addr_width_p'(zynq_pkg::CSR_PROF_1):     rdata_n = ctrl.profile[1*dw_lp +: dw_lp];
         csr_addr_width_p'(zynq_pkg::CSR_PROF_2):     rdata_n = ctrl.profile[2*dw_lp +: dw_lp];
         csr_addr_width_p'(zynq_pkg::CSR_PROF_3):     rdata_n = ctrl.profile[3*dw_lp +: dw_lp];
         default:                                     rdata_n = '0;
      endcase
   end

   // one read per cycle, each answered exactly one cycle later
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         rdata_v_r <= 1'b0;
      end else begin
         rdata_v_r <= csr_rd_v_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (csr_rd_v_i) begin
         rdata_r <= rdata_n;
      end
   end

   assign csr_rdata_v_o = rdata_v_r;
   assign csr_rdata_o   = rdata_r;

endmodule

`default_nettype wire

/* flist.f */
zynq_pkg.sv
pl_ctrl_if.sv
csr_bank.sv
addr_remap.sv
mem_profiler.sv
zynq_top.sv
tb_zynq_top.sv

/* mem_profiler.sv */
`timescale 1ns/1ns
`default_nettype none

module mem_profiler (
   input  wire logic clk_i,
   input  wire logic reset_i,
   pl_ctrl_if.prof   ctrl
);

   logic [zynq_pkg::prof_regions-1:0] hit_onehot;
   logic [zynq_pkg::prof_regions-1:0] profile_r;

   // decode the region of this cycle's request, nothing when idle
   always_comb begin
      hit_onehot = '0;
      if (ctrl.dram_acc_v) begin
         hit_onehot[ctrl.dram_acc_region] = 1'b1;
      end
   end

   ////////////////////////////////////////
   // sticky bitmap
   ////////////////////////////////////////

   // a held core clears the map and ignores traffic
   always_ff @(posedge clk_i) begin
      if (reset_i || ctrl.core_reset) begin
         profile_r <= '0;
      end else begin
         profile_r <= profile_r | hit_onehot;
      end
   end

   assign ctrl.profile = profile_r;

endmodule

`default_nettype wire

/* pl_ctrl_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface pl_ctrl_if;

   // core held in reset, from the run bit
   logic core_reset;

   // host DRAM base for the remap adder
   logic [zynq_pkg::host_data_width-1:0] dram_base;

   // sticky region bitmap
   logic [zynq_pkg::prof_regions-1:0] profile;

   // one strobe per DRAM request with its region
   logic dram_acc_v;
   logic [zynq_pkg::prof_msb-zynq_pkg::prof_lsb:0] dram_acc_region;

   modport csr (
      output core_reset, dram_base,
      input  profile
   );

   modport remap (
      input  dram_base,
      output dram_acc_v, dram_acc_region
   );

   modport prof (
      input  core_reset, dram_acc_v, dram_acc_region,
      output profile
   );

endinterface

`default_nettype wire

/* tb_zynq_top.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_zynq_top;

   localparam int max_cycles_lp = 2000;

   logic        clk_i;
   logic        reset_i;
   logic        csr_wr_v_i;
   logic        csr_rd_v_i;
   logic [2:0]  csr_addr_i;
   logic [31:0] csr_wdata_i;
   logic        csr_rdata_v_o;
   logic [31:0] csr_rdata_o;
   logic        host_v_i;
   logic [29:0] host_addr_i;
   logic        core_v_o;
   logic [31:0] core_addr_o;
   logic        dram_v_i;
   logic        dram_we_i;
   logic [31:0] dram_addr_i;
   logic        mem_v_o;
   logic        mem_we_o;
   logic [31:0] mem_addr_o;
   logic        core_reset_o;

   // model state and one-cycle-delayed expectations
   logic [31:0]  mdl_resetn;
   logic [31:0]  mdl_base;
   logic [127:0] mdl_prof;
   logic         exp_rd_v;
   logic [31:0]  exp_rdata;
   logic         exp_core_v;
   logic [31:0]  exp_core_addr;
   logic         exp_mem_v;
   logic         exp_mem_we;
   logic [31:0]  exp_mem_addr;

   int value_errs = 0;
   int strobe_errs = 0;
   int read_checks = 0;
   int cycle_cnt = 0;
   int unsigned rnd;
   logic [31:0] addr;

   zynq_top #(.csr_addr_width_p(3)) dut (.*);

   initial begin
      clk_i = 1'b0;
      forever #2 clk_i = ~clk_i;
   end

   ////////////////////////////////////////
   // reference rules
   ////////////////////////////////////////

   // top bit flips, bits 30:28 zero, low 28 bits pass
   function automatic logic [31:0] host_xlate(input logic [29:0] a);
      return {~a[29], 3'b000, a[27:0]};
   endfunction

   function automatic logic [31:0] dram_remap(input logic [31:0] a, input logic [31:0] base);
      return (a ^ 32'h8000_0000) + base;
   endfunction

   // 8 MB regions, 128 of them
   function automatic logic [6:0] region_of(input logic [31:0] a);
      return a[29:23];
   endfunction

   function automatic logic [31:0] expected_read(input logic [2:0] a, input logic [31:0] resetn,
                                                 input logic [31:0] base, input logic [127:0] prof);
      case (a)
         3'd0:    return resetn;
         3'd1:    return base;
         3'd2:    return prof[31:0];
         3'd3:    return prof[63:32];
         3'd4:    return prof[95:64];
         3'd5:    return prof[127:96];
         default: return 32'h0;
      endcase
   endfunction

   always @(posedge clk_i) begin
      if (reset_i) begin
         exp_rd_v   <= 1'b0;
         exp_core_v <= 1'b0;
         exp_mem_v  <= 1'b0;
         mdl_resetn <= '0;
         mdl_base   <= '0;
         mdl_prof   <= '0;
      end else begin
         exp_rd_v <= csr_rd_v_i;
         if (csr_rd_v_i) begin
            exp_rdata <= expected_read(csr_addr_i, mdl_resetn, mdl_base, mdl_prof);
         end
         if (csr_wr_v_i && csr_addr_i == 3'd0) begin
            mdl_resetn <= csr_wdata_i;
         end
         if (csr_wr_v_i && csr_addr_i == 3'd1) begin
            mdl_base <= csr_wdata_i;
         end
         exp_core_v    <= host_v_i;
         exp_core_addr <= host_xlate(host_addr_i);
         exp_mem_v     <= dram_v_i;
         exp_mem_we    <= dram_we_i;
         exp_mem_addr  <= dram_remap(dram_addr_i, mdl_base);
         // profile is held clear while the core is in reset
         if (!mdl_resetn[0]) begin
            mdl_prof <= '0;
         end else if (dram_v_i) begin
            mdl_prof[region_of(dram_addr_i)] <= 1'b1;
         end
      end
   end

   ////////////////////////////////////////
   // compare
   ////////////////////////////////////////

   task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
      if (exp !== act) begin
         $display("[ERROR] %0t ns %s expected %h actual %h", $time, name, exp, act);
         value_errs++;
      end
   endtask

   task automatic check_strobe(input string name, input logic exp, input logic act);
      if (exp && !act) begin
         $display("%0t ns: %s missing, a request got no response", $time, name);
         strobe_errs++;
      end
      if (!exp && act) begin
         $display("%0t ns: %s extra, a response came with no request", $time, name);
         strobe_errs++;
      end
   endtask

   // outputs settle well before the falling edge
   always @(negedge clk_i) begin
      if (!reset_i) begin
         check_value("core_reset_o", {31'b0, ~mdl_resetn[0]}, {31'b0, core_reset_o});
         check_strobe("csr_rdata_v_o", exp_rd_v, csr_rdata_v_o);
         check_strobe("core_v_o", exp_core_v, core_v_o);
         check_strobe("mem_v_o", exp_mem_v, mem_v_o);
         if (exp_rd_v && csr_rdata_v_o) begin
            check_value("csr_rdata_o", exp_rdata, csr_rdata_o);
            read_checks++;
         end
         if (exp_core_v && core_v_o) begin
            check_value("core_addr_o", exp_core_addr, core_addr_o);
         end
         if (exp_mem_v && mem_v_o) begin
            check_value("mem_addr_o", exp_mem_addr, mem_addr_o);
            check_value("mem_we_o", {31'b0, exp_mem_we}, {31'b0, mem_we_o});
         end
      end
   end

   ////////////////////////////////////////
   // stimulus
   ////////////////////////////////////////

   task automatic idle_cycle();
      @(posedge clk_i);
      csr_wr_v_i <= 1'b0;
      csr_rd_v_i <= 1'b0;
      host_v_i   <= 1'b0;
      dram_v_i   <= 1'b0;
   endtask

   task automatic csr_write(input logic [2:0] a, input logic [31:0] d);
      @(posedge clk_i);
      csr_wr_v_i  <= 1'b1;
      csr_rd_v_i  <= 1'b0;
      csr_addr_i  <= a;
      csr_wdata_i <= d;
   endtask

   task automatic csr_read(input logic [2:0] a);
      @(posedge clk_i);
      csr_wr_v_i <= 1'b0;
      csr_rd_v_i <= 1'b1;
      csr_addr_i <= a;
   endtask

   task automatic read_range(input int first, input int last);
      for (int a = first; a <= last; a++) begin
         csr_read(a[2:0]);
      end
   endtask

   task automatic host_req(input logic [29:0] a);
      @(posedge clk_i);
      csr_wr_v_i  <= 1'b0;
      csr_rd_v_i  <= 1'b0;
      host_v_i    <= 1'b1;
      host_addr_i <= a;
   endtask

   task automatic dram_req(input logic we, input logic [31:0] a);
      @(posedge clk_i);
      csr_wr_v_i  <= 1'b0;
      csr_rd_v_i  <= 1'b0;
      host_v_i    <= 1'b0;
      dram_v_i    <= 1'b1;
      dram_we_i   <= we;
      dram_addr_i <= a;
   endtask

   task automatic dram_burst(input int n);
      for (int i = 0; i < n; i++) begin
         dram_req($urandom % 2, $urandom);
      end
      idle_cycle();
   endtask

   initial begin
      while (cycle_cnt < max_cycles_lp) begin
         @(posedge clk_i);
         cycle_cnt++;
      end
      $display("run stopped after %0d cycles without reaching the end of the tests", cycle_cnt);
      $display("value errors %0d, strobe errors %0d", value_errs, strobe_errs);
      $display("Something failed");
      $finish;
   end

   initial begin
      rnd = $urandom(32'h83834f20);
      reset_i     = 1'b1;
      csr_wr_v_i  = 1'b0;
      csr_rd_v_i  = 1'b0;
      csr_addr_i  = '0;
      csr_wdata_i = '0;
      host_v_i    = 1'b0;
      host_addr_i = '0;
      dram_v_i    = 1'b0;
      dram_we_i   = 1'b0;
      dram_addr_i = '0;
      repeat (5) @(posedge clk_i);
      reset_i <= 1'b0;

      // reset state, every register reads zero
      read_range(0, 7);
      idle_cycle();

      // writes, read-only words and back-to-back reads
      csr_write(3'd1, $urandom);
      csr_write(3'd0, 32'h1);
      for (int a = 2; a <= 7; a++) begin
         csr_write(a[2:0], $urandom);
      end
      read_range(0, 7);
      csr_write(3'd1, $urandom);
      csr_read(3'd1);
      csr_read(3'd0);
      idle_cycle();

      // host window, bit 29 alternates between the two windows
      for (int i = 0; i < 200; i++) begin
         addr = $urandom;
         addr[29] = i[0];
         host_req(addr[29:0]);
         if ($urandom % 5 == 0) begin
            idle_cycle();
         end
      end
      idle_cycle();

      // DRAM remap with a fresh base
      csr_write(3'd1, $urandom);
      dram_burst(200);
      read_range(2, 5);

      // holding the core clears the profile and hides traffic
      csr_write(3'd0, 32'h0);
      read_range(2, 5);
      dram_burst(20);
      csr_write(3'd0, 32'h1);
      read_range(2, 5);
      dram_burst(30);
      read_range(0, 7);
      idle_cycle();
      repeat (3) @(negedge clk_i);

      $display("reads checked %0d, value errors %0d, strobe errors %0d",
               read_checks, value_errs, strobe_errs);
      if (value_errs == 0 && strobe_errs == 0 && read_checks > 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* zynq_pkg.sv */
`default_nettype none

package zynq_pkg;

   ////////////////////////////////////////
   // widths
   ////////////////////////////////////////

   // register data and core addresses share one width
   localparam int host_data_width = 32;

   // the host window drops the top two address bits
   localparam int host_win_width = 30;

   typedef logic [host_data_width-1:0] core_addr_t;

   ////////////////////////////////////////
   // translation constants
   ////////////////////////////////////////

   // core DRAM starts here, remap strips it before adding the host base
   localparam core_addr_t bp_dram_base = 32'h8000_0000;

   // one profiler bit per 8 MB region of the core address
   localparam int prof_regions = 128;
   localparam int prof_msb = 29;
   localparam int prof_lsb = 23;

   ////////////////////////////////////////
   // host register map
   ////////////////////////////////////////

   typedef enum logic [2:0] {
      CSR_SYS_RESETN = 3'd0,
      CSR_DRAM_BASE  = 3'd1,
      // profiler words, lowest first, read only
      CSR_PROF_0     = 3'd2,
      CSR_PROF_1     = 3'd3,
      CSR_PROF_2     = 3'd4,
      CSR_PROF_3     = 3'd5
   } csr_addr_e;

endpackage

`default_nettype wire

/* zynq_top.sv */
`timescale 1ns/1ns
`default_nettype none

module zynq_top #(
   parameter int csr_addr_width_p = 3
) (
   input  wire logic                                 clk_i,
   input  wire logic                                 reset_i,

   // host register access
   input  wire logic                                 csr_wr_v_i,
   input  wire logic                                 csr_rd_v_i,
   input  wire logic [csr_addr_width_p-1:0]          csr_addr_i,
   input  wire logic [zynq_pkg::host_data_width-1:0] csr_wdata_i,
   output logic                                      csr_rdata_v_o,
   output logic [zynq_pkg::host_data_width-1:0]      csr_rdata_o,

   // host window into the core
   input  wire logic                                 host_v_i,
   input  wire logic [zynq_pkg::host_win_width-1:0]  host_addr_i,
   output logic                                      core_v_o,
   output zynq_pkg::core_addr_t                      core_addr_o,

   // core DRAM requests out to host memory
   input  wire logic                                 dram_v_i,
   input  wire logic                                 dram_we_i,
   input  wire zynq_pkg::core_addr_t                 dram_addr_i,
   output logic                                      mem_v_o,
   output logic                                      mem_we_o,
   output zynq_pkg::core_addr_t                      mem_addr_o,

   output logic                                      core_reset_o
);

   pl_ctrl_if ctrl ();

   ////////////////////////////////////////
   // blocks
   ////////////////////////////////////////

   csr_bank #(
      .csr_addr_width_p(csr_addr_width_p)
   ) csr (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .csr_wr_v_i   (csr_wr_v_i),
      .csr_rd_v_i   (csr_rd_v_i),
      .csr_addr_i   (csr_addr_i),
      .csr_wdata_i  (csr_wdata_i),
      .csr_rdata_v_o(csr_rdata_v_o),
      .csr_rdata_o  (csr_rdata_o),
      .core_reset_o (core_reset_o),
      .ctrl         (ctrl.csr)
   );

   addr_remap remap (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .host_v_i   (host_v_i),
      .host_addr_i(host_addr_i),
      .core_v_o   (core_v_o),
      .core_addr_o(core_addr_o),
      .dram_v_i   (dram_v_i),
      .dram_we_i  (dram_we_i),
      .dram_addr_i(dram_addr_i),
      .mem_v_o    (mem_v_o),
      .mem_we_o   (mem_we_o),
      .mem_addr_o (mem_addr_o),
      .ctrl       (ctrl.remap)
   );

   mem_profiler prof (
      .clk_i  (clk_i),
      .reset_i(reset_i),
      .ctrl   (ctrl.prof)
   );

endmodule

`default_nettype wire
